/* verilog/lcd_defs.svh */
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// 480x272 panel timing, in disp_clk cycles and lines
`define LCD_H_ACTIVE   480
`define LCD_H_FP       2
`define LCD_H_BP       2
`define LCD_H_SYNC     41   // hsync low width

`define LCD_V_ACTIVE   272
`define LCD_V_FP       2
`define LCD_V_BP       2
`define LCD_V_SYNC     10   // vsync low width, in lines

// derived counts
`define LCD_H_TOTAL    (`LCD_H_SYNC + `LCD_H_FP + `LCD_H_ACTIVE + `LCD_H_BP)
`define LCD_V_TOTAL    (`LCD_V_SYNC + `LCD_V_FP + `LCD_V_ACTIVE + `LCD_V_BP)
`define LCD_H_START    (`LCD_H_SYNC + `LCD_H_FP)   // first active h count
`define LCD_V_START    (`LCD_V_SYNC + `LCD_V_FP)   // first active v count

// overlay layers
`define LCD_NUM_LAYERS 4

`endif

/* verilog/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // pixel coordinate or counter value
    typedef logic [9:0] coord_t;

    // selects a layer during configuration
    typedef logic [1:0] layer_sel_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one record per disp_clk cycle
    typedef struct packed {
        logic   active;  // inside the visible window
        logic   hsync;   // active low
        logic   vsync;   // active low
        coord_t x;       // zero outside the window
        coord_t y;
    } beam_t;

    // bounds are inclusive
    typedef struct packed {
        logic   enable;
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        rgb_t   color;
    } rect_t;

    typedef struct packed {
        logic hit;
        rgb_t color;
    } layer_out_t;

endpackage

`default_nettype wire

/* verilog/lcd_timing_gen.sv */
`default_nettype none
`timescale 1ns/1ps

`include "lcd_defs.svh"

module lcd_timing_gen (
    input  logic           disp_clk,
    input  logic           rst_n,
    input  logic           en,
    output lcd_pkg::beam_t beam
);

    localparam lcd_pkg::coord_t H_LAST   = lcd_pkg::coord_t'(`LCD_H_TOTAL - 1);
    localparam lcd_pkg::coord_t V_LAST   = lcd_pkg::coord_t'(`LCD_V_TOTAL - 1);
    localparam lcd_pkg::coord_t H_SYNC   = lcd_pkg::coord_t'(`LCD_H_SYNC);
    localparam lcd_pkg::coord_t V_SYNC   = lcd_pkg::coord_t'(`LCD_V_SYNC);
    localparam lcd_pkg::coord_t H_START  = lcd_pkg::coord_t'(`LCD_H_START);
    localparam lcd_pkg::coord_t V_START  = lcd_pkg::coord_t'(`LCD_V_START);
    localparam lcd_pkg::coord_t H_ACTIVE = lcd_pkg::coord_t'(`LCD_H_ACTIVE);
    localparam lcd_pkg::coord_t V_ACTIVE = lcd_pkg::coord_t'(`LCD_V_ACTIVE);
    localparam lcd_pkg::coord_t H_END    = H_START + H_ACTIVE;   // first blank count after data
    localparam lcd_pkg::coord_t V_END    = V_START + V_ACTIVE;

    lcd_pkg::coord_t h_cnt;
    lcd_pkg::coord_t v_cnt;
    logic            h_act;
    logic            v_act;
    lcd_pkg::beam_t  beam_d;

    // free-running raster counters, parked at zero while disabled
    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!en) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;   // end of frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);

    always_comb begin
        beam_d        = '0;
        beam_d.hsync  = (h_cnt >= H_SYNC);   // low during the sync pulse
        beam_d.vsync  = (v_cnt >= V_SYNC);
        beam_d.active = h_act && v_act;
        if (h_act && v_act) begin
            beam_d.x = h_cnt - H_START;
            beam_d.y = v_cnt - V_START;
        end
    end

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            beam <= '0;
        end else if (!en) begin
            beam <= '0;   // all panel levels low
        end else begin
            beam <= beam_d;
        end
    end

    // coordinates never leave the panel while active
    a_beam_in_panel: assert property (
        @(posedge disp_clk) disable iff (!rst_n)
        beam.active |-> (beam.x < H_ACTIVE) && (beam.y < V_ACTIVE)
    );

endmodule

`default_nettype wire

/* verilog/lcd_rect_layer.sv */
`default_nettype none
`timescale 1ns/1ps

module lcd_rect_layer #(
    parameter int LAYER_ID = 0
) (
    input  logic                disp_clk,
    input  logic                rst_n,
    input  logic                cfg_we,
    input  lcd_pkg::layer_sel_t cfg_sel,
    input  lcd_pkg::rect_t      cfg_rect,
    input  lcd_pkg::beam_t      beam,
    output lcd_pkg::layer_out_t hit_out
);

    localparam lcd_pkg::layer_sel_t MY_SEL = lcd_pkg::layer_sel_t'(LAYER_ID);

    logic           load;
    lcd_pkg::rect_t rect_q;    // enable, bounds and colour
    logic           in_x;
    logic           in_y;

    assign load = cfg_we && (cfg_sel == MY_SEL);

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            rect_q <= '0;   // layer starts disabled
        end else if (load) begin
            rect_q <= cfg_rect;
        end
    end

    // inclusive window test
    assign in_x = (beam.x >= rect_q.x0) && (beam.x <= rect_q.x1);
    assign in_y = (beam.y >= rect_q.y0) && (beam.y <= rect_q.y1);

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_out <= '0;
        end else begin
            hit_out.hit   <= rect_q.enable && beam.active && in_x && in_y;
            hit_out.color <= rect_q.color;
        end
    end

    // an enabled rectangle must not be inverted
    a_rect_ordered: assert property (
        @(posedge disp_clk) disable iff (!rst_n)
        (load && cfg_rect.enable) |->
            (cfg_rect.x0 <= cfg_rect.x1) && (cfg_rect.y0 <= cfg_rect.y1)
    );

endmodule

`default_nettype wire

/* verilog/lcd_layer_mixer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "lcd_defs.svh"

module lcd_layer_mixer (
    input  logic                                            disp_clk,
    input  logic                                            rst_n,
    input  logic                                            en,
    input  lcd_pkg::beam_t                                  beam,
    input  lcd_pkg::layer_out_t [`LCD_NUM_LAYERS-1:0]       hits,
    input  lcd_pkg::rgb_t                                   bg_color,
    output logic                                            valid_draw,
    output lcd_pkg::coord_t                                 h_pos,
    output lcd_pkg::coord_t                                 v_pos,
    output logic [7:0]                                      red,
    output logic [7:0]                                      green,
    output logic [7:0]                                      blue,
    output logic                                            disp_hsync,
    output logic                                            disp_vsync
);

    lcd_pkg::beam_t beam_q;   // lines up with hits
    lcd_pkg::rgb_t  pix;

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            beam_q <= '0;
        end else begin
            beam_q <= beam;
        end
    end

    // lowest layer index wins, so walk from the top down
    always_comb begin
        pix = '0;
        if (beam_q.active) begin
            pix = bg_color;
            for (int i = `LCD_NUM_LAYERS - 1; i >= 0; i--) begin
                if (hits[i].hit) begin
                    pix = hits[i].color;
                end
            end
        end
    end

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_draw <= 1'b0;
            h_pos      <= '0;
            v_pos      <= '0;
            red        <= '0;
            green      <= '0;
            blue       <= '0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
        end else if (!en) begin
            valid_draw <= 1'b0;   // panel pins low while paused
            h_pos      <= '0;
            v_pos      <= '0;
            red        <= '0;
            green      <= '0;
            blue       <= '0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
        end else begin
            valid_draw <= beam_q.active;
            h_pos      <= beam_q.x;
            v_pos      <= beam_q.y;
            red        <= pix.red;
            green      <= pix.green;
            blue       <= pix.blue;
            disp_hsync <= beam_q.hsync;
            disp_vsync <= beam_q.vsync;
        end
    end

    // blanking carries no colour
    a_blank_black: assert property (
        @(posedge disp_clk) disable iff (!rst_n)
        !valid_draw |-> ({red, green, blue} == '0)
    );

endmodule

`default_nettype wire

/* verilog/lcd_overlay_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "lcd_defs.svh"

module lcd_overlay_top (
    input  logic                disp_clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                cfg_we,
    input  lcd_pkg::layer_sel_t cfg_sel,
    input  lcd_pkg::rect_t      cfg_rect,
    input  lcd_pkg::rgb_t       bg_color,
    output logic                valid_draw,
    output lcd_pkg::coord_t     h_pos,
    output lcd_pkg::coord_t     v_pos,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue,
    output logic                disp_hsync,
    output logic                disp_vsync
);

    lcd_pkg::beam_t                             beam;
    lcd_pkg::layer_out_t [`LCD_NUM_LAYERS-1:0]  hits;   // one entry per layer

    lcd_timing_gen u_timing (
        .disp_clk (disp_clk),
        .rst_n    (rst_n),
        .en       (en),
        .beam     (beam)
    );

    for (genvar i = 0; i < `LCD_NUM_LAYERS; i++) begin : g_layer
        lcd_rect_layer #(
            .LAYER_ID (i)
        ) u_layer (
            .disp_clk (disp_clk),
            .rst_n    (rst_n),
            .cfg_we   (cfg_we),
            .cfg_sel  (cfg_sel),
            .cfg_rect (cfg_rect),
            .beam     (beam),
            .hit_out  (hits[i])
        );
    end

    lcd_layer_mixer u_mixer (
        .disp_clk   (disp_clk),
        .rst_n      (rst_n),
        .en         (en),
        .beam       (beam),
        .hits       (hits),
        .bg_color   (bg_color),
        .valid_draw (valid_draw),
        .h_pos      (h_pos),
        .v_pos      (v_pos),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .disp_hsync (disp_hsync),
        .disp_vsync (disp_vsync)
    );

endmodule

`default_nettype wire

/* bench/lcd_overlay_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "lcd_defs.svh"

module lcd_overlay_tb;

    localparam int CLK_HALF   = 10;   // 20 ns period
    localparam int LINE_CYC   = `LCD_H_TOTAL;
    localparam int FRAME_CYC  = `LCD_H_TOTAL * `LCD_V_TOTAL;
    localparam int WAIT_LIMIT = 2 * FRAME_CYC + 100;   // any raster position fits
    localparam int HSYNC_LOW  = `LCD_H_SYNC;
    localparam int VSYNC_LOW  = `LCD_V_SYNC * `LCD_H_TOTAL;
    localparam int PAUSE_CYC  = 40;
    localparam int NUM_STEPS  = 25;

    localparam lcd_pkg::rgb_t BG = 24'h203040;
    localparam lcd_pkg::rgb_t C0 = 24'hff0000;
    localparam lcd_pkg::rgb_t C1 = 24'h00ff00;
    localparam lcd_pkg::rgb_t C3 = 24'h0000ff;

    // one table entry, either a layer write or a probe
    typedef struct packed {
        logic                is_write;
        lcd_pkg::layer_sel_t sel;
        lcd_pkg::rect_t      rect;
        lcd_pkg::coord_t     x;
        lcd_pkg::coord_t     y;
        lcd_pkg::rgb_t       exp;
    } step_t;

    logic                disp_clk;
    logic                rst_n;
    logic                en;
    logic                cfg_we;
    lcd_pkg::layer_sel_t cfg_sel;
    lcd_pkg::rect_t      cfg_rect;
    lcd_pkg::rgb_t       bg_color;
    logic                valid_draw;
    lcd_pkg::coord_t     h_pos;
    lcd_pkg::coord_t     v_pos;
    logic [7:0]          red;
    logic [7:0]          green;
    logic [7:0]          blue;
    logic                disp_hsync;
    logic                disp_vsync;

    step_t steps [NUM_STEPS];

    lcd_overlay_top u_lcd_overlay_top (
        .disp_clk   (disp_clk),
        .rst_n      (rst_n),
        .en         (en),
        .cfg_we     (cfg_we),
        .cfg_sel    (cfg_sel),
        .cfg_rect   (cfg_rect),
        .bg_color   (bg_color),
        .valid_draw (valid_draw),
        .h_pos      (h_pos),
        .v_pos      (v_pos),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .disp_hsync (disp_hsync),
        .disp_vsync (disp_vsync)
    );

    initial begin
        disp_clk = 1'b0;
        forever #CLK_HALF disp_clk = ~disp_clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic step_t make_write(input int sel, input logic enable,
                                         input int x0, input int y0,
                                         input int x1, input int y1,
                                         input lcd_pkg::rgb_t color);
        step_t s;
        s             = '0;
        s.is_write    = 1'b1;
        s.sel         = lcd_pkg::layer_sel_t'(sel);
        s.rect.enable = enable;
        s.rect.x0     = lcd_pkg::coord_t'(x0);
        s.rect.y0     = lcd_pkg::coord_t'(y0);
        s.rect.x1     = lcd_pkg::coord_t'(x1);
        s.rect.y1     = lcd_pkg::coord_t'(y1);
        s.rect.color  = color;
        return s;
    endfunction

    function automatic step_t make_probe(input int x, input int y, input lcd_pkg::rgb_t exp);
        step_t s;
        s     = '0;
        s.x   = lcd_pkg::coord_t'(x);
        s.y   = lcd_pkg::coord_t'(y);
        s.exp = exp;
        return s;
    endfunction

    task automatic build_table();
        steps[0]  = make_probe(0, 0, BG);       // empty panel corners and centre
        steps[1]  = make_probe(479, 0, BG);
        steps[2]  = make_probe(0, 271, BG);
        steps[3]  = make_probe(479, 271, BG);
        steps[4]  = make_probe(240, 136, BG);
        steps[5]  = make_write(0, 1'b1, 100, 50, 200, 120, C0);
        steps[6]  = make_probe(150, 80, C0);
        steps[7]  = make_probe(100, 80, C0);    // edges are inside
        steps[8]  = make_probe(200, 80, C0);
        steps[9]  = make_probe(150, 50, C0);
        steps[10] = make_probe(150, 120, C0);
        steps[11] = make_probe(99, 80, BG);     // one pixel outside
        steps[12] = make_probe(201, 80, BG);
        steps[13] = make_probe(150, 49, BG);
        steps[14] = make_probe(150, 121, BG);
        steps[15] = make_write(1, 1'b1, 300, 150, 400, 220, C1);
        steps[16] = make_write(3, 1'b1, 350, 180, 450, 250, C3);
        steps[17] = make_probe(375, 200, C1);   // overlap goes to layer 1
        steps[18] = make_probe(420, 240, C3);
        steps[19] = make_probe(320, 160, C1);
        steps[20] = make_write(1, 1'b0, 300, 150, 400, 220, C1);
        steps[21] = make_probe(375, 200, C3);
        steps[22] = make_probe(320, 160, BG);
        steps[23] = make_probe(150, 80, C0);    // after the en pause
        steps[24] = make_probe(375, 200, C3);
    endtask

    function automatic logic sync_level(input logic vert);
        return vert ? disp_vsync : disp_hsync;
    endfunction

    task automatic wait_sync_edge(input logic vert, input logic rise);
        int   n;
        logic prev;
        n    = 0;
        prev = sync_level(vert);
        @(negedge disp_clk);
        while (!(prev != rise && sync_level(vert) == rise) && n < WAIT_LIMIT) begin
            prev = sync_level(vert);
            n++;
            @(negedge disp_clk);
        end
        if (!(prev != rise && sync_level(vert) == rise)) begin
            stop_run("timed out waiting for an edge on a sync output");
        end
    endtask

    task automatic wait_pixel(input lcd_pkg::coord_t x, input lcd_pkg::coord_t y);
        int n;
        n = 0;
        @(negedge disp_clk);
        while (!(valid_draw && h_pos == x && v_pos == y) && n < WAIT_LIMIT) begin
            n++;
            @(negedge disp_clk);
        end
        if (!(valid_draw && h_pos == x && v_pos == y)) begin
            stop_run($sformatf("timed out waiting for pixel (%0d,%0d)", x, y));
        end
    endtask

    task automatic write_layer(input step_t s);
        @(negedge disp_clk);
        cfg_sel  = s.sel;
        cfg_rect = s.rect;
        cfg_we   = 1'b1;
        @(negedge disp_clk);
        cfg_we   = 1'b0;
        repeat (4) @(negedge disp_clk);   // new rectangle through the pipeline
    endtask

    task automatic run_steps(input int first, input int last);
        string where;
        for (int i = first; i <= last; i++) begin
            if (steps[i].is_write) begin
                write_layer(steps[i]);
            end else begin
                wait_pixel(steps[i].x, steps[i].y);
                where = $sformatf("at (%0d,%0d)", steps[i].x, steps[i].y);
                check_value({"red ", where}, 32'(red), 32'(steps[i].exp.red));
                check_value({"green ", where}, 32'(green), 32'(steps[i].exp.green));
                check_value({"blue ", where}, 32'(blue), 32'(steps[i].exp.blue));
            end
        end
    endtask

    // period and low width of one line
    task automatic check_line_timing();
        int   period;
        int   low;
        logic prev;
        wait_sync_edge(1'b0, 1'b0);
        period = 0;
        low    = 0;
        prev   = 1'b0;
        while (!(prev && !disp_hsync) && period <= 2 * LINE_CYC) begin
            if (!disp_hsync) begin
                low++;
            end
            prev = disp_hsync;
            period++;
            @(negedge disp_clk);
        end
        if (!(prev && !disp_hsync)) begin
            stop_run("disp_hsync did not fall again within two line times");
        end
        check_value("hsync period", 32'(period), 32'(LINE_CYC));
        check_value("hsync low cycles", 32'(low), 32'(HSYNC_LOW));
    endtask

    task automatic check_vsync_width();
        int low;
        wait_sync_edge(1'b1, 1'b0);
        low = 0;
        while (!disp_vsync && low <= 2 * VSYNC_LOW) begin
            low++;
            @(negedge disp_clk);
        end
        if (!disp_vsync) begin
            stop_run("disp_vsync stayed low far too long");
        end
        check_value("vsync low cycles", 32'(low), 32'(VSYNC_LOW));
    endtask

    // every active pixel of one frame, in raster order
    task automatic check_coord_walk();
        int n;
        int run;
        wait_sync_edge(1'b1, 1'b1);
        for (int line = 0; line < `LCD_V_ACTIVE; line++) begin
            n = 0;
            while (!valid_draw && n < 4 * LINE_CYC) begin
                n++;
                @(negedge disp_clk);
            end
            if (!valid_draw) begin
                stop_run($sformatf("active line %0d never started", line));
            end
            run = 0;
            while (valid_draw && run <= `LCD_H_ACTIVE) begin
                check_value("h_pos", 32'(h_pos), 32'(run));
                check_value("v_pos", 32'(v_pos), 32'(line));
                run++;
                @(negedge disp_clk);
            end
            check_value("valid_draw run length", 32'(run), 32'(`LCD_H_ACTIVE));
        end
    endtask

    task automatic check_pause();
        @(negedge disp_clk);
        en = 1'b0;
        @(negedge disp_clk);   // outputs cleared on this edge
        for (int k = 0; k < PAUSE_CYC; k++) begin
            check_value("disp_hsync", 32'(disp_hsync), 32'h0);
            check_value("disp_vsync", 32'(disp_vsync), 32'h0);
            check_value("valid_draw", 32'(valid_draw), 32'h0);
            check_value("h_pos", 32'(h_pos), 32'h0);
            check_value("v_pos", 32'(v_pos), 32'h0);
            check_value("rgb", 32'({red, green, blue}), 32'h0);
            @(negedge disp_clk);
        end
        en = 1'b1;
    endtask

    // blanking carries no colour
    always @(negedge disp_clk) begin
        if (rst_n && !valid_draw) begin
            check_value("blank rgb", 32'({red, green, blue}), 32'h0);
        end
    end

    initial begin
        rst_n    = 1'b0;
        en       = 1'b0;
        cfg_we   = 1'b0;
        cfg_sel  = '0;
        cfg_rect = '0;
        bg_color = BG;
        build_table();
        repeat (3) @(negedge disp_clk);
        rst_n = 1'b1;
        en    = 1'b1;

        run_steps(0, 4);   // background only
        check_line_timing();
        check_vsync_width();
        check_coord_walk();
        run_steps(5, 22);   // single rectangle, priority, disable

        check_pause();
        check_line_timing();
        check_vsync_width();
        run_steps(23, 24);   // configuration kept

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/lcd_pkg.sv
verilog/lcd_timing_gen.sv
verilog/lcd_rect_layer.sv
verilog/lcd_layer_mixer.sv
verilog/lcd_overlay_top.sv
bench/lcd_overlay_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it; exit status gives pass or fail
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module lcd_overlay_tb \
    -f tb.f \
    --Mdir obj_dir \
    -o lcd_overlay_sim \
    && ./obj_dir/lcd_overlay_sim \
    || { echo "simulation run failed"; exit 1; }
